/* hdl/npcPkg.sv */
package npcPkg;

  localparam int addrW = 32;
  localparam int jumpW = 26;
  localparam int offsetW = 16;
  localparam int excEnableW = 4;

  typedef logic [addrW-1:0] addrT;

  localparam addrT excVector = 32'h0000_0008;  // single exception entry

  // next-PC source as decoded in ID
  typedef enum logic [2:0] {
    plus4   = 3'd0,
    branch  = 3'd1,
    jump    = 3'd2,
    jumpReg = 3'd3,
    intSrc  = 3'd4,
    epcSrc  = 3'd5
  } pcSrcE;

  typedef enum logic [2:0] {
    idle          = 3'd0,
    jrWait        = 3'd1,  // register operand not ready yet
    jrIssue       = 3'd2,
    branchWait    = 3'd3,
    branchResolve = 3'd4   // branch is in EX this cycle
  } seqStateE;

  // one-hot, matches the coprocessor cause field
  typedef enum logic [3:0] {
    causeNone   = 4'd0,
    causeInt    = 4'd1,
    causeSys    = 4'd2,
    causeUnimpl = 4'd4,
    causeOvf    = 4'd8
  } causeE;

endpackage

/* hdl/excArbiter.sv */
`timescale 1ns/100ps

module excArbiter (
  input  npcPkg::seqStateE              state,
  input  logic                          pcWrIn,
  input  logic                          intReq,
  input  logic                          sysReq,
  input  logic                          unimplReq,
  input  logic                          ovfReq,
  input  logic [npcPkg::excEnableW-1:0] status,
  input  logic                          branchEx,
  input  npcPkg::addrT                  pcIf,
  input  npcPkg::addrT                  pcId,
  input  npcPkg::addrT                  pcEx,
  input  npcPkg::addrT                  epcIn,
  input  npcPkg::addrT                  jumpRegister,
  input  npcPkg::addrT                  pendingTarget,
  output logic                          excTaken,
  output npcPkg::addrT                  epc,
  output logic                          epcWr,
  output npcPkg::causeE                 cause,
  output logic                          ifIdFlush,
  output logic                          idExFlush,
  output logic                          exMeFlush
);

  logic intEn;
  logic sysEn;
  logic unimplEn;
  logic ovfEn;
  logic inIdle;

  // status bit order: int, sys, unimpl, ovf
  assign intEn    = intReq & status[0];
  assign sysEn    = sysReq & status[1];
  assign unimplEn = unimplReq & status[2];
  assign ovfEn    = ovfReq & status[3];

  // sys and unimpl only make sense outside a jump/branch sequence
  assign inIdle = (state == npcPkg::idle);

  assign epcWr = excTaken;

  always_comb begin
    excTaken  = 1'b0;
    epc       = epcIn;
    cause     = npcPkg::causeNone;
    ifIdFlush = 1'b0;
    idExFlush = 1'b0;
    exMeFlush = 1'b0;

    if (intEn) begin
      excTaken = 1'b1;
      cause    = npcPkg::causeInt;
      case (state)
        npcPkg::jrIssue: begin
          epc       = jumpRegister;  // resume at the jump target
          ifIdFlush = 1'b1;
        end
        npcPkg::jrWait, npcPkg::branchWait: begin
          epc       = pcId;
          ifIdFlush = 1'b1;
          idExFlush = 1'b1;
        end
        default: begin
          if (state == npcPkg::branchResolve && branchEx) begin
            epc       = pendingTarget;  // taken branch target
            ifIdFlush = 1'b1;
            idExFlush = 1'b1;
          end else if (!pcWrIn) begin
            // stalled, IF holds a refetch so restart from ID
            epc       = pcId;
            ifIdFlush = 1'b1;
            idExFlush = 1'b1;
          end else begin
            epc       = pcIf;
            ifIdFlush = 1'b1;
          end
        end
      endcase
    end else if (ovfEn) begin
      excTaken  = 1'b1;
      cause     = npcPkg::causeOvf;
      epc       = pcEx;  // faulting instr in EX
      ifIdFlush = 1'b1;
      idExFlush = 1'b1;
      exMeFlush = 1'b1;
    end else if (unimplEn && inIdle) begin
      excTaken = 1'b1;
      cause    = npcPkg::causeUnimpl;
      epc      = pcIf;
    end else if (sysEn && inIdle) begin
      excTaken = 1'b1;
      cause    = npcPkg::causeSys;
      epc      = pcIf;
    end
  end

endmodule

/* hdl/pcSequencer.sv */
`timescale 1ns/100ps

module pcSequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pcWrIn,
  input  logic                       excTaken,
  input  npcPkg::pcSrcE              pcSrc,
  input  logic                       branchEx,
  input  npcPkg::addrT               pcIf,
  input  logic [npcPkg::offsetW-1:0] offset,
  input  logic [npcPkg::jumpW-1:0]   jumpTarget,
  input  npcPkg::addrT               jumpRegister,
  input  npcPkg::addrT               epcIn,
  output npcPkg::addrT               pcNext,
  output logic                       pcWr,
  output logic                       eret,
  output logic                       ifIdFlush,
  output logic                       idExFlush,
  output npcPkg::seqStateE           state,
  output npcPkg::addrT               pendingTarget
);

  localparam int regionW = npcPkg::addrW - npcPkg::jumpW - 2;
  localparam int extW = npcPkg::addrW - npcPkg::offsetW - 2;

  npcPkg::seqStateE nextState;
  npcPkg::addrT     nextTarget;
  npcPkg::addrT     pcPlus4;
  npcPkg::addrT     jumpAddr;
  npcPkg::addrT     branchAddr;
  logic             decodeNow;

  assign pcPlus4  = pcIf + 32'd4;
  assign jumpAddr = {pcIf[npcPkg::addrW-1 -: regionW], jumpTarget, 2'b00};  // same 256MB region

  assign branchAddr = pcPlus4 + {{extW{offset[npcPkg::offsetW-1]}}, offset, 2'b00};

  // a not-taken branch frees the slot for the instruction now in ID
  assign decodeNow = (state == npcPkg::idle) ||
                     (state == npcPkg::branchResolve && !branchEx);

  always_comb begin
    pcNext     = pcPlus4;
    pcWr       = 1'b0;
    eret       = 1'b0;
    ifIdFlush  = 1'b0;
    idExFlush  = 1'b0;
    nextState  = state;
    nextTarget = pendingTarget;

    if (excTaken) begin
      // arbiter owns the flushes here
      pcNext    = npcPkg::excVector;
      pcWr      = 1'b1;
      nextState = npcPkg::idle;
    end else if (!pcWrIn) begin
      pcNext = pcIf;  // stall, hold everything
    end else if (decodeNow) begin
      nextState = npcPkg::idle;
      case (pcSrc)
        npcPkg::jump: begin
          pcNext = jumpAddr;
          pcWr   = 1'b1;
        end
        npcPkg::branch: begin
          pcWr       = 1'b1;  // keep fetching down the fall-through path
          nextTarget = branchAddr;
          nextState  = npcPkg::branchWait;
        end
        npcPkg::jumpReg: begin
          nextState = npcPkg::jrWait;
        end
        npcPkg::epcSrc: begin
          pcNext = epcIn;
          pcWr   = 1'b1;
          eret   = 1'b1;
        end
        default: begin
          pcWr = 1'b1;  // plus4, intSrc
        end
      endcase
    end else begin
      case (state)
        npcPkg::jrWait: begin
          ifIdFlush = 1'b1;
          nextState = npcPkg::jrIssue;
        end
        npcPkg::jrIssue: begin
          pcNext    = jumpRegister;
          pcWr      = 1'b1;
          ifIdFlush = 1'b1;
          nextState = npcPkg::idle;
        end
        npcPkg::branchWait: begin
          ifIdFlush = 1'b1;
          nextState = npcPkg::branchResolve;
        end
        npcPkg::branchResolve: begin
          // only reached with branchEx high
          pcNext    = pendingTarget;
          pcWr      = 1'b1;
          ifIdFlush = 1'b1;
          idExFlush = 1'b1;
          nextState = npcPkg::idle;
        end
        default: begin
          nextState = npcPkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= npcPkg::idle;
      pendingTarget <= '0;
    end else begin
      state         <= nextState;
      pendingTarget <= nextTarget;
    end
  end

endmodule

/* hdl/npcTop.sv */
`timescale 1ns/100ps

module npcTop (
  input  logic                          clk,
  input  logic                          rst,
  input  npcPkg::addrT                  pcIf,
  input  npcPkg::addrT                  pcId,
  input  npcPkg::addrT                  pcEx,
  input  npcPkg::addrT                  epcIn,
  input  npcPkg::addrT                  jumpRegister,
  input  logic [npcPkg::offsetW-1:0]    offset,
  input  logic [npcPkg::jumpW-1:0]      jumpTarget,
  input  npcPkg::pcSrcE                 pcSrc,
  input  logic                          branchEx,
  input  logic                          pcWrIn,
  input  logic                          intReq,
  input  logic                          sysReq,
  input  logic                          unimplReq,
  input  logic                          ovfReq,
  input  logic [npcPkg::excEnableW-1:0] status,
  output logic                          pcWr,
  output npcPkg::addrT                  pcNext,
  output npcPkg::addrT                  epc,
  output logic                          epcWr,
  output logic                          ifIdFlush,
  output logic                          idExFlush,
  output logic                          exMeFlush,
  output npcPkg::causeE                 cause,
  output logic                          eret
);

  npcPkg::seqStateE state;
  npcPkg::addrT     pendingTarget;
  logic             excTaken;
  logic             excIfIdFlush;
  logic             excIdExFlush;
  logic             seqIfIdFlush;
  logic             seqIdExFlush;

  excArbiter arb (
    .state         (state),
    .pcWrIn        (pcWrIn),
    .intReq        (intReq),
    .sysReq        (sysReq),
    .unimplReq     (unimplReq),
    .ovfReq        (ovfReq),
    .status        (status),
    .branchEx      (branchEx),
    .pcIf          (pcIf),
    .pcId          (pcId),
    .pcEx          (pcEx),
    .epcIn         (epcIn),
    .jumpRegister  (jumpRegister),
    .pendingTarget (pendingTarget),
    .excTaken      (excTaken),
    .epc           (epc),
    .epcWr         (epcWr),
    .cause         (cause),
    .ifIdFlush     (excIfIdFlush),
    .idExFlush     (excIdExFlush),
    .exMeFlush     (exMeFlush)   // only exceptions reach EX/MEM
  );

  pcSequencer seq (
    .clk           (clk),
    .rst           (rst),
    .pcWrIn        (pcWrIn),
    .excTaken      (excTaken),
    .pcSrc         (pcSrc),
    .branchEx      (branchEx),
    .pcIf          (pcIf),
    .offset        (offset),
    .jumpTarget    (jumpTarget),
    .jumpRegister  (jumpRegister),
    .epcIn         (epcIn),
    .pcNext        (pcNext),
    .pcWr          (pcWr),
    .eret          (eret),
    .ifIdFlush     (seqIfIdFlush),
    .idExFlush     (seqIdExFlush),
    .state         (state),
    .pendingTarget (pendingTarget)
  );

  assign ifIdFlush = excIfIdFlush | seqIfIdFlush;
  assign idExFlush = excIdExFlush | seqIdExFlush;

endmodule

/* sim/npcTb.sv */
`timescale 1ns/100ps

module npcTb;

  localparam int maxVec = 64;
  localparam int clkPeriod = 40;

  // one stimulus line, single-bit fields padded to a hex digit
  typedef struct packed {
    logic [31:0] pcIf;
    logic [31:0] pcId;
    logic [31:0] pcEx;
    logic [31:0] epcIn;
    logic [31:0] jumpRegister;
    logic [15:0] offset;
    logic [27:0] jumpTarget;
    logic [3:0]  pcSrc;
    logic [3:0]  branchEx;
    logic [3:0]  pcWrIn;
    logic [3:0]  req;     // same bit order as status
    logic [3:0]  status;
    logic [3:0]  pcWr;
    logic [31:0] pcNext;
    logic [31:0] epc;
    logic [3:0]  epcWr;
    logic [3:0]  flush;   // ifId, idEx, exMe
    logic [3:0]  cause;
    logic [3:0]  eret;
  } vecT;

  logic [$bits(vecT)-1:0] vecMem [0:maxVec-1];

  logic                          clk;
  logic                          rst;
  npcPkg::addrT                  pcIf;
  npcPkg::addrT                  pcId;
  npcPkg::addrT                  pcEx;
  npcPkg::addrT                  epcIn;
  npcPkg::addrT                  jumpRegister;
  logic [npcPkg::offsetW-1:0]    offset;
  logic [npcPkg::jumpW-1:0]      jumpTarget;
  npcPkg::pcSrcE                 pcSrc;
  logic                          branchEx;
  logic                          pcWrIn;
  logic                          intReq;
  logic                          sysReq;
  logic                          unimplReq;
  logic                          ovfReq;
  logic [npcPkg::excEnableW-1:0] status;
  logic                          pcWr;
  npcPkg::addrT                  pcNext;
  npcPkg::addrT                  epc;
  logic                          epcWr;
  logic                          ifIdFlush;
  logic                          idExFlush;
  logic                          exMeFlush;
  npcPkg::causeE                 cause;
  logic                          eret;

  int vecCount;
  int errCount;
  int checkCount;

  npcTop dut (
    .clk(clk), .rst(rst), .pcIf(pcIf), .pcId(pcId), .pcEx(pcEx), .epcIn(epcIn),
    .jumpRegister(jumpRegister), .offset(offset), .jumpTarget(jumpTarget),
    .pcSrc(pcSrc), .branchEx(branchEx), .pcWrIn(pcWrIn), .intReq(intReq),
    .sysReq(sysReq), .unimplReq(unimplReq), .ovfReq(ovfReq), .status(status),
    .pcWr(pcWr), .pcNext(pcNext), .epc(epc), .epcWr(epcWr), .ifIdFlush(ifIdFlush),
    .idExFlush(idExFlush), .exMeFlush(exMeFlush), .cause(cause), .eret(eret)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic checkVal(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("FAIL %0t ns %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic applyVec(input vecT v);
    pcIf         <= v.pcIf;
    pcId         <= v.pcId;
    pcEx         <= v.pcEx;
    epcIn        <= v.epcIn;
    jumpRegister <= v.jumpRegister;
    offset       <= v.offset;
    jumpTarget   <= v.jumpTarget[npcPkg::jumpW-1:0];
    pcSrc        <= npcPkg::pcSrcE'(v.pcSrc[2:0]);
    branchEx     <= v.branchEx[0];
    pcWrIn       <= v.pcWrIn[0];
    intReq       <= v.req[0];
    sysReq       <= v.req[1];
    unimplReq    <= v.req[2];
    ovfReq       <= v.req[3];
    status       <= v.status;
  endtask

  task automatic compareOutputs(input vecT v);
    checkVal("pcWr", v.pcWr[0], pcWr);
    checkVal("pcNext", v.pcNext, pcNext);
    checkVal("epc", v.epc, epc);
    checkVal("epcWr", v.epcWr[0], epcWr);
    checkVal("ifIdFlush", v.flush[2], ifIdFlush);
    checkVal("idExFlush", v.flush[1], idExFlush);
    checkVal("exMeFlush", v.flush[0], exMeFlush);
    checkVal("cause", v.cause, cause);
    checkVal("eret", v.eret[0], eret);
  endtask

  initial begin
    vecT v;
    clk = 1'b0;
    rst = 1'b1;
    pcIf = '0;
    pcId = '0;
    pcEx = '0;
    epcIn = '0;
    jumpRegister = '0;
    offset = '0;
    jumpTarget = '0;
    pcSrc = npcPkg::plus4;
    branchEx = 1'b0;
    pcWrIn = 1'b0;
    intReq = 1'b0;
    sysReq = 1'b0;
    unimplReq = 1'b0;
    ovfReq = 1'b0;
    status = '0;
    errCount = 0;
    checkCount = 0;

    // all-ones marks the end of the vectors
    for (int i = 0; i < maxVec; i++) begin
      vecMem[i] = '1;
    end
    $readmemh("sim/npcStimulus.txt", vecMem);
    vecCount = 0;
    while (vecCount < maxVec && vecMem[vecCount] !== '1) begin
      vecCount++;
    end
    if (vecCount == 0) begin
      $display("no stimulus vectors could be read from the data file");
      errCount++;
    end

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < vecCount; i++) begin
      v = vecMem[i];
      @(posedge clk);
      applyVec(v);
      @(negedge clk);  // outputs settled, state not yet updated
      compareOutputs(v);
    end

    $display("vectors: %0d  checks: %0d  errors: %0d", vecCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog, vector count is known after time zero
  initial begin
    #1;
    #((vecCount + 10) * clkPeriod);
    $display("timeout: the run did not finish within the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

/* build.f */
hdl/npcPkg.sv
hdl/excArbiter.sv
hdl/pcSequencer.sv
hdl/npcTop.sv
sim/npcTb.sv

/* sim/npcStimulus.txt */
// pcIf_pcId_pcEx_epcIn_jumpRegister_offset_jumpTarget_{src,brEx,pcWrIn,req,status}
// then expected: pcWr_pcNext_epc_{epcWr,flush,cause,eret}
00400000_003ffffc_003ffff8_00400100_00402000_0000_0000000_00000_0_00400000_00400100_0000
00400000_003ffffc_003ffff8_00400100_00402000_0000_0000000_00100_1_00400004_00400100_0000
00400004_00400000_003ffffc_00400100_00402000_0000_0000000_40100_1_00400008_00400100_0000
9abc0010_9abc000c_9abc0008_00400100_00402000_0000_1234567_20100_1_948d159c_00400100_0000
00400020_0040001c_00400018_00400100_00402000_0000_0000000_50100_1_00400100_00400100_0001
00400100_004000fc_004000f8_00400100_00402000_0000_0000000_30100_0_00400104_00400100_0000
00400100_004000fc_004000f8_00400100_00402000_0000_0000000_00000_0_00400100_00400100_0000
00400100_004000fc_004000f8_00400100_00402000_0000_0000000_00100_0_00400104_00400100_0400
00400104_00400100_004000fc_00400100_00402000_0000_0000000_00100_1_00402000_00400100_0400
00402000_00401ffc_00401ff8_00400100_00402000_0010_0000000_10100_1_00402004_00400100_0000
00402004_00402000_00401ffc_00400100_00402000_0000_0000000_00100_0_00402008_00400100_0400
00402008_00402004_00402000_00400100_00402000_0000_0000000_01100_1_00402044_00400100_0600
00402044_00402040_0040203c_00400100_00402000_fff8_0000000_10100_1_00402048_00400100_0000
00402048_00402044_00402040_00400100_00402000_0000_0000000_00100_0_0040204c_00400100_0400
0040204c_00402048_00402044_00400100_00402000_0000_0000000_01100_1_00402028_00400100_0600
00402028_00402024_00402020_00400100_00402000_0004_0000000_10100_1_0040202c_00400100_0000
0040202c_00402028_00402024_00400100_00402000_0000_0000000_00100_0_00402030_00400100_0400
00402030_0040202c_00402028_00400100_00402000_0000_0000100_20100_1_00000400_00400100_0000
00500000_004ffffc_004ffff8_00400100_00402000_0000_0000000_001ff_1_00000008_00500000_1410
00500000_004ffffc_004ffff8_00400100_00402000_0000_0000000_001fe_1_00000008_004ffff8_1780
00500000_004ffffc_004ffff8_00400100_00402000_0000_0000000_001f6_1_00000008_00500000_1040
00500000_004ffffc_004ffff8_00400100_00402000_0000_0000000_001f2_1_00000008_00500000_1020
00500000_004ffffc_004ffff8_00400100_00402000_0000_0000000_001f0_1_00500004_00400100_0000
00500100_005000fc_005000f8_00400100_00402000_0000_0000000_30100_0_00500104_00400100_0000
00500100_005000fc_005000f8_00400100_00402000_0000_0000000_00122_0_00500104_00400100_0400
00500104_00500100_005000fc_00400100_00402000_0000_0000000_00111_1_00000008_00402000_1410
00000008_00000004_00000000_00400100_00402000_0000_0000000_30100_0_0000000c_00400100_0000
0000000c_00000008_00000004_00400100_00402000_0000_0000000_00111_1_00000008_00000008_1610
00600000_005ffffc_005ffff8_00400100_00402000_0020_0000000_10100_1_00600004_00400100_0000
00600004_00600000_005ffffc_00400100_00402000_0000_0000000_00111_1_00000008_00600000_1610
00000008_00000004_00000000_00400100_00402000_0020_0000000_10100_1_0000000c_00400100_0000
0000000c_00000008_00000004_00400100_00402000_0000_0000000_00100_0_00000010_00400100_0400
00000010_0000000c_00000008_00400100_00402000_0000_0000000_01111_1_00000008_0000008c_1610
00700000_006ffffc_006ffff8_00400100_00402000_0000_0000000_00011_1_00000008_006ffffc_1610
00000008_00700000_006ffffc_00400100_00402000_0000_0000000_00000_0_00000008_00400100_0000
